// ==== hdl/fpAddPkg.sv ====
`default_nettype none

package fpAddPkg;

    // field widths of an IEEE single-precision word
    parameter int FpWidth = 32;
    parameter int ExpWidth = 8;
    parameter int ManWidth = 23;
    // mantissa plus hidden bit
    parameter int SigWidth = ManWidth + 1;
    // wide enough to hold a count of SigWidth
    parameter int LzcWidth = 5;

    typedef logic [FpWidth-1:0] fpWordT;
    typedef logic [ExpWidth-1:0] expT;
    typedef logic [ManWidth-1:0] manT;
    typedef logic [SigWidth-1:0] sigT;
    typedef logic [LzcWidth-1:0] lzcT;

    // default lane constants
    parameter fpWordT FpOne = 32'h3f80_0000;
    parameter fpWordT FpMinusOne = 32'hbf80_0000;

    // valid_i to done_o, in clock cycles
    // split 1, lane 4, normalize 1
    parameter int PipeDepth = 6;

endpackage

`default_nettype wire

// ==== hdl/leadZeroCount.sv ====
`timescale 1ns/1ps
`default_nettype none

module leadZeroCount import fpAddPkg::*; (
    input  sigT sig_i,
    output lzcT count_o
);

    // scan up from the lsb, the highest set bit gets the last word
    always_comb begin
        // all-zero input
        count_o = lzcT'(SigWidth);
        for (int i = 0; i < SigWidth; i++) begin
            if (sig_i[i]) begin
                count_o = lzcT'(SigWidth - 1 - i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fpOperandSplit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpOperandSplit import fpAddPkg::*; (
    input  logic   clk_i,
    input  logic   rstn_i,
    input  logic   valid_i,
    input  fpWordT a_i,
    output logic   aSign_o,
    output expT    aExp_o,
    output sigT    aSig_o,
    output logic   vld_o
);

    // raw fields of the incoming word
    expT aExp;
    manT aMan;
    logic aNormal;

    assign aExp = a_i[FpWidth-2 -: ExpWidth];
    assign aMan = a_i[ManWidth-1:0];
    // biased exponent 0 means zero or denormal, both flushed
    assign aNormal = |aExp;

    // stage 1 valid
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            vld_o <= 1'b0;
        end else begin
            vld_o <= valid_i;
        end
    end

    // stage 1 fields, loaded only with a new operand
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            aSign_o <= a_i[FpWidth-1];
            aExp_o <= aExp;
            // hidden bit follows the exponent, mantissa cleared on flush
            aSig_o <= aNormal ? {1'b1, aMan} : '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fpConstAddLane.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpConstAddLane import fpAddPkg::*; #(
    parameter fpWordT LaneConst = FpOne
) (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            aSign_i,
    input  expT             aExp_i,
    input  sigT             aSig_i,
    input  logic            vld_i,
    output logic            sign_o,
    output expT             bigExp_o,
    output logic [SigWidth:0] sum_o,
    output logic            vld_o
);

    // constant fields, always a normal number so hidden bit is 1
    localparam logic KSign = LaneConst[FpWidth-1];
    localparam expT KExp = LaneConst[FpWidth-2 -: ExpWidth];
    localparam sigT KSig = {1'b1, LaneConst[ManWidth-1:0]};

    logic aBig;
    logic vld2, vld3, vld4;

    logic sign2, sub2;
    expT  bigExp2, smallExp2;
    sigT  bigSig2, smallSig2;

    logic sign3, sub3;
    expT  bigExp3, expDiff3;
    sigT  bigSig3, smallSig3;

    logic sign4, sub4;
    expT  bigExp4;
    sigT  bigSig4, alignSig4;

    // magnitude compare, exponent first then significand
    // ties go to the constant
    assign aBig = (aExp_i > KExp) | ((aExp_i == KExp) & (aSig_i > KSig));

    // private valid chain, stages 2 to 5
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            vld2 <= 1'b0;
            vld3 <= 1'b0;
            vld4 <= 1'b0;
            vld_o <= 1'b0;
        end else begin
            vld2 <= vld_i;
            vld3 <= vld2;
            vld4 <= vld3;
            vld_o <= vld4;
        end
    end

    // stage 2: swap so the larger magnitude is big
    always_ff @(posedge clk_i) begin
        if (vld_i) begin
            sign2 <= aBig ? aSign_i : KSign;
            sub2 <= aSign_i ^ KSign;
            bigExp2 <= aBig ? aExp_i : KExp;
            smallExp2 <= aBig ? KExp : aExp_i;
            bigSig2 <= aBig ? aSig_i : KSig;
            smallSig2 <= aBig ? KSig : aSig_i;
        end
    end

    // stage 3: exponent difference, never negative after the swap
    always_ff @(posedge clk_i) begin
        if (vld2) begin
            expDiff3 <= bigExp2 - smallExp2;
            sign3 <= sign2;
            sub3 <= sub2;
            bigExp3 <= bigExp2;
            bigSig3 <= bigSig2;
            smallSig3 <= smallSig2;
        end
    end

    // stage 4: align small operand, shifted-out bits are lost
    always_ff @(posedge clk_i) begin
        if (vld3) begin
            alignSig4 <= (expDiff3 >= ExpWidth'(SigWidth)) ? '0 : (smallSig3 >> expDiff3);
            sign4 <= sign3;
            sub4 <= sub3;
            bigExp4 <= bigExp3;
            bigSig4 <= bigSig3;
        end
    end

    // stage 5: add on matching signs, else subtract
    // msb of sum is the carry
    always_ff @(posedge clk_i) begin
        if (vld4) begin
            if (sub4) begin
                sum_o <= {1'b0, bigSig4} - {1'b0, alignSig4};
            end else begin
                sum_o <= {1'b0, bigSig4} + {1'b0, alignSig4};
            end
            sign_o <= sign4;
            bigExp_o <= bigExp4;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fpNormalizeBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpNormalizeBank import fpAddPkg::*; #(
    parameter int NumLanes = 2
) (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            vld_i,
    input  logic   [NumLanes-1:0]           sign_i,
    input  expT    [NumLanes-1:0]           bigExp_i,
    input  logic   [NumLanes-1:0][SigWidth:0] sum_i,
    output fpWordT [NumLanes-1:0]           result_o,
    output logic                            done_o
);

    // end of the valid chain
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            done_o <= 1'b0;
        end else begin
            done_o <= vld_i;
        end
    end

    for (genvar g = 0; g < NumLanes; g++) begin : gLane
        lzcT    lzc;
        sigT    sig;
        sigT    shifted;
        logic   carry;
        fpWordT word;
        fpWordT resultQ;

        assign carry = sum_i[g][SigWidth];
        assign sig = sum_i[g][SigWidth-1:0];

        leadZeroCount i_leadZeroCount (
            .sig_i   (sig),
            .count_o (lzc)
        );

        // hidden bit lands in the msb
        assign shifted = sig << lzc;

        always_comb begin
            if (carry) begin
                // one bit right, lsb truncated
                word = {sign_i[g], bigExp_i[g] + 1'b1, sig[SigWidth-1:1]};
            end else if (sig == '0) begin
                // exact cancellation, always +0
                word = '0;
            end else begin
                word = {sign_i[g], bigExp_i[g] - ExpWidth'(lzc), shifted[ManWidth-1:0]};
            end
        end

        // result holds until the next valid item
        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                resultQ <= '0;
            end else if (vld_i) begin
                resultQ <= word;
            end
        end

        assign result_o[g] = resultQ;
    end

endmodule

`default_nettype wire

// ==== hdl/fpAddConstTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpAddConstTop import fpAddPkg::*; #(
    parameter int NumLanes = 2,
    // lane 0 sits in the low word
    parameter fpWordT [NumLanes-1:0] LaneConsts = {FpMinusOne, FpOne}
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  valid_i,
    input  fpWordT                a_i,
    output fpWordT [NumLanes-1:0] result_o,
    output logic                  done_o
);

    // stage 1 operand, broadcast to every lane
    logic aSign;
    expT  aExp;
    sigT  aSig;
    logic vld1;

    // stage 5, one set per lane
    logic [NumLanes-1:0]             laneSign;
    expT  [NumLanes-1:0]             laneExp;
    logic [NumLanes-1:0][SigWidth:0] laneSum;
    logic [NumLanes-1:0]             laneVld;

    fpOperandSplit i_fpOperandSplit (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .valid_i (valid_i),
        .a_i     (a_i),
        .aSign_o (aSign),
        .aExp_o  (aExp),
        .aSig_o  (aSig),
        .vld_o   (vld1)
    );

    for (genvar g = 0; g < NumLanes; g++) begin : gLane
        fpConstAddLane #(
            .LaneConst (LaneConsts[g])
        ) i_fpConstAddLane (
            .clk_i    (clk_i),
            .rstn_i   (rstn_i),
            .aSign_i  (aSign),
            .aExp_i   (aExp),
            .aSig_i   (aSig),
            .vld_i    (vld1),
            .sign_o   (laneSign[g]),
            .bigExp_o (laneExp[g]),
            .sum_o    (laneSum[g]),
            .vld_o    (laneVld[g])
        );
    end

    // all lanes run in lockstep, lane 0 valid stands for the rest
    fpNormalizeBank #(
        .NumLanes (NumLanes)
    ) i_fpNormalizeBank (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .vld_i    (laneVld[0]),
        .sign_i   (laneSign),
        .bigExp_i (laneExp),
        .sum_i    (laneSum),
        .result_o (result_o),
        .done_o   (done_o)
    );

endmodule

`default_nettype wire

// ==== dv/tbClockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
    parameter int PeriodNs = 4,
    parameter int ResetCycles = 16
) (
    output logic clk_o,
    output logic rstn_o
);

    // free-running clock, starts low
    initial begin
        clk_o = 1'b0;
        forever #(PeriodNs / 2) clk_o = ~clk_o;
    end

    // starts high so the async reset sees a real falling edge
    initial begin
        rstn_o = 1'b1;
        #1 rstn_o = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        // release just after an edge, like the other inputs
        #1 rstn_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== dv/fpAddConst_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpAddConstChk import fpAddPkg::*; #(
    parameter int NumLanes = 2
) (
    input logic                  clk_i,
    input logic                  rstn_i,
    input logic                  valid_i,
    input fpWordT [NumLanes-1:0] result_i,
    input logic                  done_i
);

    // failed assertions, read by the testbench at the end
    int assertFails = 0;

    // no done pulse while reset is held
    doneLowInReset: assert property (@(posedge clk_i) !rstn_i |-> !done_i)
        else begin
            assertFails++;
            $error("done_o high while rstn_i is low");
        end

    // fixed latency, one pulse per accepted word
    doneFollowsValid: assert property (@(posedge clk_i) disable iff (!rstn_i)
        done_i == $past(valid_i, PipeDepth))
        else begin
            assertFails++;
            $error("done_o does not match valid_i delayed by %0d cycles", PipeDepth);
        end

    // results only move with done
    resultHolds: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !done_i |-> $stable(result_i))
        else begin
            assertFails++;
            $error("result_o changed in a cycle without done_o");
        end

endmodule

`default_nettype wire

// ==== dv/fpAddConstTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpAddConstTb import fpAddPkg::*; ();

    localparam int NumLanes = 2;
    localparam int PeriodNs = 4;
    localparam int TableLen = 6;
    localparam int NumRandom = 200;
    // pipeline plus some slack
    localparam int DrainLimit = PipeDepth + 10;
    localparam int WatchdogNs = (TableLen + NumRandom + 40) * PeriodNs * 2;

    // columns: operand, lane 0 (a + 1.0), lane 1 (a - 1.0)
    fpWordT stimTable [TableLen][3] = '{
        '{32'h4000_0000, 32'h4040_0000, 32'h3f80_0000},
        '{32'h3f80_0000, 32'h4000_0000, 32'h0000_0000},
        '{32'hbf80_0000, 32'h0000_0000, 32'hc000_0000},
        '{32'h3f00_0000, 32'h3fc0_0000, 32'hbf00_0000},
        '{32'h0000_0000, 32'h3f80_0000, 32'hbf80_0000},
        // 2^30, the constant is shifted out entirely
        '{32'h4e80_0000, 32'h4e80_0000, 32'h4e80_0000}
    };

    logic clk;
    logic rstn;
    logic valid;
    fpWordT aIn;
    fpWordT [NumLanes-1:0] result;
    logic done;

    integer seed = 32'h8d57;
    int cycle = 0;
    int errCount = 0;
    int checkCount = 0;
    int testsPassed = 0;
    int testsFailed = 0;

    // scoreboard, one entry per word in flight
    int dueQ[$];
    fpWordT expQ0[$];
    fpWordT expQ1[$];
    fpWordT [NumLanes-1:0] prevResult = '0;
    int due;
    fpWordT exp0;
    fpWordT exp1;

    tbClockGen #(
        .PeriodNs    (PeriodNs),
        .ResetCycles (16)
    ) i_tbClockGen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    fpAddConstTop i_fpAddConstTop (
        .clk_i    (clk),
        .rstn_i   (rstn),
        .valid_i  (valid),
        .a_i      (aIn),
        .result_o (result),
        .done_o   (done)
    );

    bind fpAddConstTop fpAddConstChk #(
        .NumLanes (NumLanes)
    ) i_fpAddConstChk (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .valid_i  (valid_i),
        .result_i (result_o),
        .done_i   (done_o)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errCount++;
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    // reference for a + k: swap, truncating align, add or subtract, normalize
    function automatic fpWordT modelAdd(input fpWordT a, input fpWordT k);
        logic aSign, kSign, bigSign;
        expT aExp, kExp, bigExp, smallExp, diff;
        logic [SigWidth:0] aSig, kSig, bigSig, smallSig, sum;
        aSign = a[31];
        kSign = k[31];
        aExp = a[30:23];
        kExp = k[30:23];
        // zero exponent flushes to a zero significand
        aSig = (aExp == 8'd0) ? '0 : {2'b01, a[22:0]};
        kSig = {2'b01, k[22:0]};
        if (aExp > kExp || (aExp == kExp && aSig > kSig)) begin
            bigSign = aSign;
            bigExp = aExp;
            bigSig = aSig;
            smallExp = kExp;
            smallSig = kSig;
        end else begin
            bigSign = kSign;
            bigExp = kExp;
            bigSig = kSig;
            smallExp = aExp;
            smallSig = aSig;
        end
        diff = bigExp - smallExp;
        smallSig = (diff >= 8'd24) ? '0 : smallSig >> diff;
        sum = (aSign == kSign) ? bigSig + smallSig : bigSig - smallSig;
        if (sum[24]) begin
            return {bigSign, bigExp + 8'd1, sum[23:1]};
        end
        if (sum == '0) begin
            return '0;
        end
        for (int i = 0; i < SigWidth && !sum[23]; i++) begin
            sum = sum << 1;
            bigExp = bigExp - 8'd1;
        end
        return {bigSign, bigExp, sum[22:0]};
    endfunction

    // about one word in sixteen gets a zero exponent
    function automatic fpWordT randomWord();
        logic [31:0] bits;
        logic [31:0] pick;
        expT e;
        bits = $random(seed);
        pick = $random(seed);
        if (pick[3:0] == 4'd0) begin
            e = 8'd0;
        end else begin
            e = 8'(32'd1 + (pick[31:4] % 28'd253));
        end
        return {bits[31], e, bits[22:0]};
    endfunction

    // entered and left 1 ns after a rising edge, valid left high
    task automatic sendWord(input fpWordT a, input fpWordT e0, input fpWordT e1);
        valid = 1'b1;
        aIn = a;
        dueQ.push_back(cycle + PipeDepth);
        expQ0.push_back(e0);
        expQ1.push_back(e1);
        @(posedge clk);
        #1;
    endtask

    task automatic idleCycles(input int n);
        valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic waitDrain(input string testName);
        int waited;
        waited = 0;
        while (dueQ.size() != 0 && waited < DrainLimit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (dueQ.size() != 0) begin
            errCount++;
            $display("Error: test %s timed out waiting for done_o, %0d results missing",
                     testName, dueQ.size());
            dueQ.delete();
            expQ0.delete();
            expQ1.delete();
        end
    endtask

    task automatic checkIdleOutputs();
        checkValue("done_o", 32'(done), 32'd0);
        for (int i = 0; i < NumLanes; i++) begin
            checkValue($sformatf("result_o[%0d]", i), result[i], 32'd0);
        end
    endtask

    task automatic endTest(input string name, input int errBefore);
        if (errCount == errBefore) begin
            testsPassed++;
            $display("test %s: ok, %0d checks so far", name, checkCount);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, errCount - errBefore);
        end
    endtask

    // sampled mid-cycle, away from the edge where outputs move
    always @(negedge clk) begin
        if (rstn) begin
            if (done && dueQ.size() == 0) begin
                errCount++;
                $display("Error: done_o pulsed at %0d ns with no word in flight", $time);
            end else if (done) begin
                due = dueQ.pop_front();
                exp0 = expQ0.pop_front();
                exp1 = expQ1.pop_front();
                checkValue("done_o cycle", cycle, due);
                checkValue("result_o[0]", result[0], exp0);
                checkValue("result_o[1]", result[1], exp1);
            end else begin
                for (int i = 0; i < NumLanes; i++) begin
                    checkValue($sformatf("result_o[%0d] hold", i), result[i], prevResult[i]);
                end
            end
            prevResult = result;
        end
    end

    initial begin
        #(WatchdogNs);
        $display("Error: run did not finish within %0d ns", WatchdogNs);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int errBefore;
        int totalErr;
        fpWordT a;
        valid = 1'b0;
        aIn = '0;

        // outputs cleared during reset and just after it
        errBefore = errCount;
        @(negedge clk);
        while (!rstn) begin
            checkIdleOutputs();
            @(negedge clk);
        end
        repeat (2) begin
            checkIdleOutputs();
            @(negedge clk);
        end
        endTest("reset", errBefore);
        @(posedge clk);
        #1;

        // one word at a time
        errBefore = errCount;
        for (int i = 0; i < TableLen; i++) begin
            sendWord(stimTable[i][0], stimTable[i][1], stimTable[i][2]);
            idleCycles(1);
            waitDrain("table");
        end
        endTest("table", errBefore);

        // back to back, six in flight
        errBefore = errCount;
        for (int i = 0; i < TableLen; i++) begin
            sendWord(stimTable[i][0], stimTable[i][1], stimTable[i][2]);
        end
        idleCycles(1);
        waitDrain("stream");
        endTest("stream", errBefore);

        // 1 to 3 idle cycles between words
        errBefore = errCount;
        for (int i = 0; i < TableLen; i++) begin
            sendWord(stimTable[i][0], stimTable[i][1], stimTable[i][2]);
            idleCycles(1 + int'($unsigned($random(seed)) % 3));
        end
        waitDrain("gaps");
        endTest("gaps", errBefore);

        // random operands against the model
        errBefore = errCount;
        for (int i = 0; i < NumRandom; i++) begin
            a = randomWord();
            sendWord(a, modelAdd(a, FpOne), modelAdd(a, FpMinusOne));
        end
        idleCycles(1);
        waitDrain("random");
        endTest("random", errBefore);

        totalErr = errCount + i_fpAddConstTop.i_fpAddConstChk.assertFails;
        $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
                 testsPassed, testsFailed, checkCount, totalErr);
        if (totalErr == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/fpAddPkg.sv
hdl/leadZeroCount.sv
hdl/fpOperandSplit.sv
hdl/fpConstAddLane.sv
hdl/fpNormalizeBank.sv
hdl/fpAddConstTop.sv
dv/tbClockGen.sv
dv/fpAddConst_chk.sv
dv/fpAddConstTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fpAddConstTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	-./$(SIM_BIN) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) && echo "sim: PASS" || (echo "sim: FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
